// File: common/mem_shim_pkg.sv
// Memory shim shared definitions
// Widths, request structs and register map

package mem_shim_pkg;

    // Virtual line address, top bits select the page
    localparam int VADDR_WIDTH       = 16;
    localparam int PAGE_BITS         = 3;
    localparam int PAGE_OFFSET_WIDTH = 13;

    // Physical line address is the page number joined with the offset
    localparam int PPN_WIDTH   = 12;
    localparam int PADDR_WIDTH = PPN_WIDTH + PAGE_OFFSET_WIDTH;

    localparam int DATA_WIDTH  = 64;
    localparam int MDATA_WIDTH = 8;
    localparam int TAG_WIDTH   = 4;

    // Request as it leaves the reorder buffer, metadata already replaced by a tag
    typedef struct packed {
        logic                   is_write;
        logic [VADDR_WIDTH-1:0] vaddr;
        logic [DATA_WIDTH-1:0]  wdata;
        logic [TAG_WIDTH-1:0]   tag;
    } afu_req_t;

    // Same request after translation
    typedef struct packed {
        logic                   is_write;
        logic [PADDR_WIDTH-1:0] paddr;
        logic [DATA_WIDTH-1:0]  wdata;
        logic [TAG_WIDTH-1:0]   tag;
    } mem_req_t;

    // APB register offsets
    localparam logic [7:0] CSR_CTRL      = 8'h00;
    localparam logic [7:0] CSR_STATUS    = 8'h04;
    localparam logic [7:0] CSR_RSP_COUNT = 8'h08;
    // Page entry i lives at CSR_PAGE_BASE + 4*i
    localparam logic [7:0] CSR_PAGE_BASE = 8'h40;

endpackage

// File: source/shim_fifo.sv
// Typed valid/ready queue

`timescale 1ns/1ps

module shim_fifo #(
    parameter int  FIFO_DEPTH = 4,
    parameter type payload_t  = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    payload_t         mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;
    // Ready drops only when every entry is occupied
    assign in_ready  = count != CNT_W'(FIFO_DEPTH);
    assign out_valid = count != '0;
    // Head entry is presented directly, so a push shows up one cycle later
    assign out_data  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // A sender that meets a full queue keeps its item until there is room
    assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && !in_ready |=> in_valid && $stable(in_data));

endmodule

// File: source/shim_csr.sv
// APB register block

`timescale 1ns/1ps

module shim_csr #(
    parameter int NUM_PAGES = 8
) (
    input  logic                                               clk,
    input  logic                                               rst_n,
    input  logic                                               psel,
    input  logic                                               penable,
    input  logic                                               pwrite,
    input  logic [7:0]                                         paddr,
    input  logic [31:0]                                        pwdata,
    output logic [31:0]                                        prdata,
    output logic                                               pready,
    output logic                                               pslverr,
    output logic                                               sort_en,
    output logic                                               vtp_en,
    output logic [NUM_PAGES-1:0]                               page_valid,
    output logic [NUM_PAGES-1:0][mem_shim_pkg::PPN_WIDTH-1:0]  page_ppn,
    input  logic                                               fault,
    input  logic [mem_shim_pkg::VADDR_WIDTH-1:0]               fault_vaddr,
    input  logic                                               rsp_fire
);

    import mem_shim_pkg::*;

    localparam int IDX_W    = $clog2(NUM_PAGES);
    localparam int PAGE_END = int'(CSR_PAGE_BASE) + 4 * NUM_PAGES;
    localparam int PPN_PAD  = 31 - PPN_WIDTH;
    localparam int STAT_PAD = 31 - VADDR_WIDTH;

    logic             access;
    logic             page_hit;
    logic [IDX_W-1:0] page_idx;
    logic             addr_err;
    logic             ro_reg;
    logic             wr_en;
    logic [31:0]      rsp_count;

    // ========================================
    // Address decode
    // ========================================

    // APB access phase, no wait states
    assign access   = psel && penable;
    assign pready   = 1'b1;
    assign page_hit = paddr >= CSR_PAGE_BASE && int'(paddr) < PAGE_END && paddr[1:0] == 2'b00;
    assign page_idx = IDX_W'((paddr - CSR_PAGE_BASE) >> 2);

    always_comb begin
        prdata   = '0;
        addr_err = 1'b0;
        ro_reg   = 1'b0;
        if (page_hit) begin
            prdata = {page_valid[page_idx], {PPN_PAD{1'b0}}, page_ppn[page_idx]};
        end else begin
            case (paddr)
                CSR_CTRL: prdata = {30'b0, vtp_en, sort_en};
                CSR_STATUS: begin
                    // Live view of the translator fault
                    prdata = {fault_vaddr, {STAT_PAD{1'b0}}, fault};
                    ro_reg = 1'b1;
                end
                CSR_RSP_COUNT: begin
                    prdata = rsp_count;
                    ro_reg = 1'b1;
                end
                default: addr_err = 1'b1;
            endcase
        end
    end

    // Error on a hole in the map or on a write to a status register
    assign pslverr = access && (addr_err || (pwrite && ro_reg));
    assign wr_en   = access && pwrite && !addr_err && !ro_reg;

    // ========================================
    // Registers
    // ========================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sort_en    <= 1'b1;
            vtp_en     <= 1'b0;
            page_valid <= '0;
            rsp_count  <= '0;
        end else begin
            if (wr_en && !page_hit) begin
                sort_en <= pwdata[0];
                vtp_en  <= pwdata[1];
            end
            if (wr_en && page_hit) begin
                page_valid[page_idx] <= pwdata[31];
            end
            if (rsp_fire) begin
                rsp_count <= rsp_count + 32'd1;
            end
        end
    end

    // Page numbers are only meaningful once the valid bit is set
    always_ff @(posedge clk) begin
        if (wr_en && page_hit) begin
            page_ppn[page_idx] <= pwdata[PPN_WIDTH-1:0];
        end
    end

    // The bus master never raises penable outside a selected transfer
    assert property (@(posedge clk) disable iff (!rst_n) penable |-> psel);

endmodule

// File: vtp/shim_vtp.sv
// Virtual to physical translator

`timescale 1ns/1ps

module shim_vtp #(
    parameter int NUM_PAGES = 8
) (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic                                              in_valid,
    output logic                                              in_ready,
    input  mem_shim_pkg::afu_req_t                            in_data,
    output logic                                              out_valid,
    input  logic                                              out_ready,
    output mem_shim_pkg::mem_req_t                            out_data,
    input  logic                                              vtp_en,
    input  logic [NUM_PAGES-1:0]                              page_valid,
    input  logic [NUM_PAGES-1:0][mem_shim_pkg::PPN_WIDTH-1:0] page_ppn,
    output logic                                              fault,
    output logic [mem_shim_pkg::VADDR_WIDTH-1:0]              fault_vaddr
);

    import mem_shim_pkg::*;

    afu_req_t             req_q;
    logic                 valid_q;
    logic [PAGE_BITS-1:0] page;
    logic                 mapped;

    // Page index from the top of the held virtual address
    assign page   = req_q.vaddr[VADDR_WIDTH-1 -: PAGE_BITS];
    assign mapped = !vtp_en || page_valid[page];

    // An unmapped request sits in the stage with its output hidden
    assign out_valid   = valid_q && mapped;
    assign fault       = valid_q && !mapped;
    assign fault_vaddr = req_q.vaddr;
    assign in_ready    = !valid_q || (out_valid && out_ready);

    always_comb begin
        out_data.is_write = req_q.is_write;
        out_data.wdata    = req_q.wdata;
        out_data.tag      = req_q.tag;
        if (vtp_en) begin
            out_data.paddr = {page_ppn[page], req_q.vaddr[PAGE_OFFSET_WIDTH-1:0]};
        end else begin
            // Pass-through mode widens the virtual line address
            out_data.paddr = PADDR_WIDTH'(req_q.vaddr);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            req_q <= in_data;
        end
    end

    // A faulted request stays put, and leaves the cycle its page turns valid
    assert property (@(posedge clk) disable iff (!rst_n)
        fault |=> $stable(req_q) && (fault || out_valid));

endmodule

// File: rsp_order/shim_rsp_order.sv
// Response reorder buffer

`timescale 1ns/1ps

module shim_rsp_order #(
    parameter int ROB_DEPTH = 16
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  req_valid,
    output logic                                  req_ready,
    input  logic                                  req_is_write,
    input  logic [mem_shim_pkg::VADDR_WIDTH-1:0]  req_vaddr,
    input  logic [mem_shim_pkg::DATA_WIDTH-1:0]   req_wdata,
    input  logic [mem_shim_pkg::MDATA_WIDTH-1:0]  req_mdata,
    output logic                                  rsp_valid,
    input  logic                                  rsp_ready,
    output logic                                  rsp_is_write,
    output logic [mem_shim_pkg::DATA_WIDTH-1:0]   rsp_rdata,
    output logic [mem_shim_pkg::MDATA_WIDTH-1:0]  rsp_mdata,
    output logic                                  fwd_valid,
    input  logic                                  fwd_ready,
    output mem_shim_pkg::afu_req_t                fwd_data,
    input  logic                                  mem_rsp_valid,
    input  logic                                  mem_rsp_is_write,
    input  logic [mem_shim_pkg::DATA_WIDTH-1:0]   mem_rsp_rdata,
    input  logic [mem_shim_pkg::TAG_WIDTH-1:0]    mem_rsp_tag,
    input  logic                                  sort_en,
    output logic                                  rsp_fire
);

    import mem_shim_pkg::*;

    localparam int CNT_W = $clog2(ROB_DEPTH + 1);

    // Per-slot payload
    logic [MDATA_WIDTH-1:0] mdata_q [ROB_DEPTH];
    logic                   wr_q    [ROB_DEPTH];
    logic [DATA_WIDTH-1:0]  rdata_q [ROB_DEPTH];
    logic [TAG_WIDTH-1:0]   arr_q   [ROB_DEPTH];

    logic [ROB_DEPTH-1:0] busy;
    logic [ROB_DEPTH-1:0] filled;
    logic [TAG_WIDTH-1:0] head;
    logic [TAG_WIDTH-1:0] tail;
    logic [TAG_WIDTH-1:0] arr_wr;
    logic [TAG_WIDTH-1:0] arr_rd;
    logic [CNT_W-1:0]     arr_cnt;
    logic                 alloc_en;
    logic                 accept;
    logic [TAG_WIDTH-1:0] rel_tag;
    logic                 rel_ok;
    logic                 release_en;

    function automatic logic [TAG_WIDTH-1:0] next_ptr(input logic [TAG_WIDTH-1:0] p);
        return (p == TAG_WIDTH'(ROB_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // ========================================
    // Request side
    // ========================================

    // Tags go out in ring order, the tail slot has to be free
    assign req_ready = alloc_en && !busy[tail] && fwd_ready;
    assign fwd_valid = req_valid && alloc_en && !busy[tail];
    assign accept    = req_valid && req_ready;

    always_comb begin
        fwd_data.is_write = req_is_write;
        fwd_data.vaddr    = req_vaddr;
        fwd_data.wdata    = req_wdata;
        fwd_data.tag      = tail;
    end

    // ========================================
    // Response side
    // ========================================

    // Sorted mode drains the oldest slot, otherwise the oldest arrival
    assign rel_tag    = sort_en ? head : arr_q[arr_rd];
    assign rel_ok     = sort_en ? (busy[head] && filled[head]) : (arr_cnt != '0);
    assign release_en = rel_ok && (!rsp_valid || rsp_ready);
    assign rsp_fire   = rsp_valid && rsp_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            alloc_en  <= 1'b0;
            busy      <= '0;
            filled    <= '0;
            head      <= '0;
            tail      <= '0;
            arr_wr    <= '0;
            arr_rd    <= '0;
            arr_cnt   <= '0;
            rsp_valid <= 1'b0;
        end else begin
            alloc_en <= 1'b1;
            if (accept) begin
                busy[tail] <= 1'b1;
                tail       <= next_ptr(tail);
            end
            if (mem_rsp_valid) begin
                filled[mem_rsp_tag] <= 1'b1;
            end
            // Arrival log feeds the unsorted drain
            if (mem_rsp_valid && !sort_en) begin
                arr_wr <= next_ptr(arr_wr);
            end
            if (release_en && !sort_en) begin
                arr_rd <= next_ptr(arr_rd);
            end
            arr_cnt <= arr_cnt + CNT_W'(mem_rsp_valid && !sort_en)
                               - CNT_W'(release_en && !sort_en);
            if (release_en) begin
                busy[rel_tag]   <= 1'b0;
                filled[rel_tag] <= 1'b0;
                rsp_valid       <= 1'b1;
            end else if (rsp_ready) begin
                rsp_valid <= 1'b0;
            end
            // Head walks past slots already freed out of order
            if (release_en && sort_en) begin
                head <= next_ptr(head);
            end else if (head != tail && !busy[head]) begin
                head <= next_ptr(head);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            mdata_q[tail] <= req_mdata;
            wr_q[tail]    <= req_is_write;
        end
        if (mem_rsp_valid) begin
            rdata_q[mem_rsp_tag] <= mem_rsp_rdata;
            arr_q[arr_wr]        <= mem_rsp_tag;
        end
        if (release_en) begin
            rsp_mdata    <= mdata_q[rel_tag];
            rsp_is_write <= wr_q[rel_tag];
            rsp_rdata    <= rdata_q[rel_tag];
        end
    end

    // Memory answers only tags in flight, once each, with the request's kind
    assert property (@(posedge clk) disable iff (!rst_n)
        mem_rsp_valid |-> busy[mem_rsp_tag] && !filled[mem_rsp_tag]
                          && mem_rsp_is_write == wr_q[mem_rsp_tag]);

endmodule

// File: source/mem_shim_top.sv
// Memory shim stack top level

`timescale 1ns/1ps

module mem_shim_top #(
    parameter int ROB_DEPTH  = 16,
    parameter int NUM_PAGES  = 8,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  psel,
    input  logic                                  penable,
    input  logic                                  pwrite,
    input  logic [7:0]                            paddr,
    input  logic [31:0]                           pwdata,
    output logic [31:0]                           prdata,
    output logic                                  pready,
    output logic                                  pslverr,
    input  logic                                  req_valid,
    output logic                                  req_ready,
    input  logic                                  req_is_write,
    input  logic [mem_shim_pkg::VADDR_WIDTH-1:0]  req_vaddr,
    input  logic [mem_shim_pkg::DATA_WIDTH-1:0]   req_wdata,
    input  logic [mem_shim_pkg::MDATA_WIDTH-1:0]  req_mdata,
    output logic                                  rsp_valid,
    input  logic                                  rsp_ready,
    output logic                                  rsp_is_write,
    output logic [mem_shim_pkg::DATA_WIDTH-1:0]   rsp_rdata,
    output logic [mem_shim_pkg::MDATA_WIDTH-1:0]  rsp_mdata,
    output logic                                  mem_req_valid,
    input  logic                                  mem_req_ready,
    output logic                                  mem_req_is_write,
    output logic [mem_shim_pkg::PADDR_WIDTH-1:0]  mem_req_paddr,
    output logic [mem_shim_pkg::DATA_WIDTH-1:0]   mem_req_wdata,
    output logic [mem_shim_pkg::TAG_WIDTH-1:0]    mem_req_tag,
    input  logic                                  mem_rsp_valid,
    input  logic                                  mem_rsp_is_write,
    input  logic [mem_shim_pkg::DATA_WIDTH-1:0]   mem_rsp_rdata,
    input  logic [mem_shim_pkg::TAG_WIDTH-1:0]    mem_rsp_tag
);

    import mem_shim_pkg::*;

    logic                                sort_en;
    logic                                vtp_en;
    logic [NUM_PAGES-1:0]                page_valid;
    logic [NUM_PAGES-1:0][PPN_WIDTH-1:0] page_ppn;
    logic                                fault;
    logic [VADDR_WIDTH-1:0]              fault_vaddr;
    logic                                rsp_fire;

    // Stage links, client side toward memory
    logic     fwd_valid, fwd_ready;
    afu_req_t fwd_data;
    logic     vreq_valid, vreq_ready;
    afu_req_t vreq_data;
    logic     preq_valid, preq_ready;
    mem_req_t preq_data;
    mem_req_t mreq_data;

    shim_csr #(.NUM_PAGES(NUM_PAGES)) csr_i (.*);

    // Tag allocation and response ordering nearest the client
    shim_rsp_order #(.ROB_DEPTH(ROB_DEPTH)) rsp_order_i (.*);

    shim_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .payload_t(afu_req_t)) req_fifo (
        .clk, .rst_n,
        .in_valid(fwd_valid), .in_ready(fwd_ready), .in_data(fwd_data),
        .out_valid(vreq_valid), .out_ready(vreq_ready), .out_data(vreq_data)
    );

    shim_vtp #(.NUM_PAGES(NUM_PAGES)) vtp_i (
        .clk, .rst_n,
        .in_valid(vreq_valid), .in_ready(vreq_ready), .in_data(vreq_data),
        .out_valid(preq_valid), .out_ready(preq_ready), .out_data(preq_data),
        .vtp_en, .page_valid, .page_ppn, .fault, .fault_vaddr
    );

    // Physical requests queue up toward the memory port
    shim_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .payload_t(mem_req_t)) mreq_fifo (
        .clk, .rst_n,
        .in_valid(preq_valid), .in_ready(preq_ready), .in_data(preq_data),
        .out_valid(mem_req_valid), .out_ready(mem_req_ready), .out_data(mreq_data)
    );

    assign mem_req_is_write = mreq_data.is_write;
    assign mem_req_paddr    = mreq_data.paddr;
    assign mem_req_wdata    = mreq_data.wdata;
    assign mem_req_tag      = mreq_data.tag;

endmodule

// File: testbench/tb_mem_shim.sv
// Memory shim stack testbench

`timescale 1ns/1ps

module tb_mem_shim;

    import mem_shim_pkg::*;

    localparam int N_REQ           = 101;
    localparam int WATCHDOG_CYCLES = N_REQ * 200 + 40 * 3 + 50;

    logic                   clk;
    logic                   rst_n;
    logic                   psel, penable, pwrite, pready, pslverr;
    logic [7:0]             paddr;
    logic [31:0]            pwdata, prdata;
    logic                   req_valid, req_ready, req_is_write;
    logic [VADDR_WIDTH-1:0] req_vaddr;
    logic [DATA_WIDTH-1:0]  req_wdata;
    logic [MDATA_WIDTH-1:0] req_mdata;
    logic                   rsp_valid, rsp_is_write;
    logic                   rsp_ready = 1'b0;
    logic [DATA_WIDTH-1:0]  rsp_rdata;
    logic [MDATA_WIDTH-1:0] rsp_mdata;
    logic                   mem_req_valid, mem_req_is_write;
    logic                   mem_req_ready = 1'b0;
    logic [PADDR_WIDTH-1:0] mem_req_paddr;
    logic [DATA_WIDTH-1:0]  mem_req_wdata;
    logic [TAG_WIDTH-1:0]   mem_req_tag;
    logic                   mem_rsp_valid = 1'b0;
    logic                   mem_rsp_is_write = 1'b0;
    logic [DATA_WIDTH-1:0]  mem_rsp_rdata = '0;
    logic [TAG_WIDTH-1:0]   mem_rsp_tag = '0;

    // Reference state kept by the testbench
    logic [31:0]            rng_state = 32'h99db5aaa;
    logic                   sort_copy = 1'b1;
    logic                   vtp_copy = 1'b0;
    logic [PPN_WIDTH-1:0]   ppn_copy [8];
    logic [MDATA_WIDTH-1:0] tag_mdata [16];
    logic                   exp_wr_md [256];
    logic [DATA_WIDTH-1:0]  exp_rd_md [256];
    logic [MDATA_WIDTH-1:0] order_q [$];
    logic [VADDR_WIDTH-1:0] vaddr_q [$];
    logic                   iswr_q [$];
    logic [DATA_WIDTH-1:0]  wdata_q [$];
    logic [TAG_WIDTH-1:0]   tag_q [$];
    logic [TAG_WIDTH-1:0]   next_tag = '0;
    logic [MDATA_WIDTH-1:0] next_mdata = '0;
    int unsigned            accepted = 0;
    int unsigned            delivered = 0;
    logic                   stall_on = 1'b0;

    // Memory model, writes land in the array when the request is taken
    logic [DATA_WIDTH-1:0]  mem_model [logic [PADDR_WIDTH-1:0]];
    logic [TAG_WIDTH-1:0]   pend_tag [$];
    logic                   pend_wr [$];
    logic [PADDR_WIDTH-1:0] pend_pa [$];

    // Expected values for the transfer at the coming rising edge
    logic                   exp_ok = 1'b0;
    logic [MDATA_WIDTH-1:0] exp_mdata = '0;
    logic                   exp_is_write = 1'b0;
    logic [DATA_WIDTH-1:0]  exp_rdata = '0;
    logic                   paddr_ok = 1'b0;
    logic [PADDR_WIDTH-1:0] exp_paddr = '0;
    logic                   exp_mem_wr = 1'b0;
    logic [DATA_WIDTH-1:0]  exp_wdata = '0;
    logic [TAG_WIDTH-1:0]   exp_tag = '0;

    mem_shim_top #(.ROB_DEPTH(16), .NUM_PAGES(8), .FIFO_DEPTH(4)) mem_shim_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run("timeout: the run did not finish within the cycle budget");
    end

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        abort_run($sformatf("error %0t: %s", $time, msg));
    endtask

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Physical line address as the page table copy says it should be
    function automatic logic [PADDR_WIDTH-1:0] xlate(input logic [VADDR_WIDTH-1:0] va);
        if (vtp_copy) begin
            return {ppn_copy[va[15:13]], va[12:0]};
        end
        return PADDR_WIDTH'(va);
    endfunction

    // ========================================
    // APB and client tasks
    // ========================================

    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        // No wait states, the access completes on this edge
        @(posedge clk);
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic set_page(input int idx, input logic valid, input logic [PPN_WIDTH-1:0] ppn);
        logic [31:0] rd;
        logic        err;
        ppn_copy[idx] = ppn;
        apb_access(1'b1, CSR_PAGE_BASE + 8'(idx * 4), {valid, 19'b0, ppn}, rd, err);
        assert (!err) else report_error($sformatf("page %0d write rejected", idx));
        apb_access(1'b0, CSR_PAGE_BASE + 8'(idx * 4), 32'b0, rd, err);
        assert (!err && rd == {valid, 19'b0, ppn})
            else report_error($sformatf("page %0d reads %h", idx, rd));
    endtask

    // Holds the request until the shim takes it, then records what should come back
    task automatic send(input logic wr, input logic [VADDR_WIDTH-1:0] va);
        logic [31:0] r;
        r            = next_random();
        req_valid    = 1'b1;
        req_is_write = wr;
        req_vaddr    = va;
        req_wdata    = {r, ~r};
        req_mdata    = next_mdata;
        while (!req_ready) @(negedge clk);
        tag_mdata[next_tag]   = next_mdata;
        exp_wr_md[next_mdata] = wr;
        if (sort_copy) begin
            order_q.push_back(next_mdata);
        end
        vaddr_q.push_back(va);
        iswr_q.push_back(wr);
        wdata_q.push_back({r, ~r});
        tag_q.push_back(next_tag);
        next_tag   = next_tag + 4'd1;
        next_mdata = next_mdata + 8'd1;
        accepted++;
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic run_traffic(input int n);
        logic [31:0] r;
        repeat (n) begin
            r = next_random();
            send(r[31:30] == 2'b00, r[15:0]);
        end
        while (delivered != accepted) @(negedge clk);
    endtask

    // ========================================
    // Memory model and response sink
    // ========================================

    always @(negedge clk) begin
        int                     idx;
        logic [MDATA_WIDTH-1:0] md;
        rsp_ready = (next_random() % 4) != 0;
        if (rsp_valid && rsp_ready) begin
            exp_ok = order_q.size() != 0;
            if (exp_ok) begin
                md           = order_q.pop_front();
                exp_mdata    = md;
                exp_is_write = exp_wr_md[md];
                exp_rdata    = exp_rd_md[md];
                delivered++;
            end
        end
        // One pending request is answered at random, in no fixed order
        mem_rsp_valid = 1'b0;
        if (pend_tag.size() != 0 && (next_random() % 3) == 0) begin
            idx              = int'(next_random() % 32'(pend_tag.size()));
            mem_rsp_valid    = 1'b1;
            mem_rsp_tag      = pend_tag[idx];
            mem_rsp_is_write = pend_wr[idx];
            if (pend_wr[idx]) begin
                mem_rsp_rdata = '0;
            end else if (mem_model.exists(pend_pa[idx])) begin
                mem_rsp_rdata = mem_model[pend_pa[idx]];
            end else begin
                mem_rsp_rdata = DATA_WIDTH'(pend_pa[idx]);
            end
            md            = tag_mdata[pend_tag[idx]];
            exp_rd_md[md] = mem_rsp_rdata;
            if (!sort_copy) begin
                order_q.push_back(md);
            end
            pend_tag.delete(idx);
            pend_wr.delete(idx);
            pend_pa.delete(idx);
        end
        mem_req_ready = (next_random() % 4) != 0;
        if (mem_req_valid && mem_req_ready) begin
            paddr_ok = vaddr_q.size() != 0;
            if (paddr_ok) begin
                exp_paddr  = xlate(vaddr_q.pop_front());
                exp_mem_wr = iswr_q.pop_front();
                exp_wdata  = wdata_q.pop_front();
                exp_tag    = tag_q.pop_front();
            end
            pend_tag.push_back(mem_req_tag);
            pend_wr.push_back(mem_req_is_write);
            pend_pa.push_back(mem_req_paddr);
            if (mem_req_is_write) begin
                mem_model[mem_req_paddr] = mem_req_wdata;
            end
        end
    end

    // ========================================
    // Checks
    // ========================================

    rsp_match: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && rsp_ready |-> exp_ok && rsp_mdata == exp_mdata
            && rsp_is_write == exp_is_write && (rsp_is_write || rsp_rdata == exp_rdata))
        else report_error($sformatf("response mdata %h data %h, expected mdata %h data %h",
                                    rsp_mdata, rsp_rdata, exp_mdata, exp_rdata));

    // Requests reach memory in issue order with their own kind, data and tag
    paddr_match: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid && mem_req_ready |-> paddr_ok && mem_req_paddr == exp_paddr
            && mem_req_is_write == exp_mem_wr && mem_req_wdata == exp_wdata
            && mem_req_tag == exp_tag)
        else report_error($sformatf("memory req paddr %h wr %b tag %h, expected %h %b %h",
                                    mem_req_paddr, mem_req_is_write, mem_req_tag,
                                    exp_paddr, exp_mem_wr, exp_tag));

    // APB has no wait states
    apb_ready: assert property (@(posedge clk) disable iff (!rst_n)
        psel && penable |-> pready)
        else report_error("APB access phase without pready");

    // Nothing may reach memory while the faulted request waits for its page
    no_issue_on_fault: assert property (@(posedge clk) disable iff (!rst_n)
        stall_on |-> !mem_req_valid)
        else report_error("memory request issued for an unmapped page");

    initial begin
        logic [31:0]            rd;
        logic                   err;
        logic [VADDR_WIDTH-1:0] va;
        rst_n        = 1'b0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        req_valid    = 1'b0;
        req_is_write = 1'b0;
        req_vaddr    = '0;
        req_wdata    = '0;
        req_mdata    = '0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // Reset values, page table readback and error responses
        apb_access(1'b0, CSR_CTRL, 32'b0, rd, err);
        assert (!err && rd == 32'h1) else report_error($sformatf("CTRL reads %h", rd));
        apb_access(1'b0, 8'h30, 32'b0, rd, err);
        assert (err) else report_error("read of an unmapped offset gave no slave error");
        apb_access(1'b1, CSR_STATUS, 32'hffff_ffff, rd, err);
        assert (err) else report_error("write to STATUS gave no slave error");
        for (int i = 0; i < 8; i++) begin
            set_page(i, 1'b1, PPN_WIDTH'(next_random()));
        end

        // In-order delivery with pass-through addresses
        run_traffic(40);

        // Translation through the page table
        vtp_copy = 1'b1;
        apb_access(1'b1, CSR_CTRL, 32'h3, rd, err);
        run_traffic(30);

        // Fault stall on page 5, then remap it
        set_page(5, 1'b0, 12'h000);
        va = {3'd5, 13'h00a5};
        send(1'b0, va);
        stall_on = 1'b1;
        repeat (12) @(negedge clk);
        apb_access(1'b0, CSR_STATUS, 32'b0, rd, err);
        assert (rd == {va, 15'b0, 1'b1}) else report_error($sformatf("STATUS reads %h", rd));
        stall_on = 1'b0;
        set_page(5, 1'b1, 12'h5a5);
        while (delivered != accepted) @(negedge clk);
        apb_access(1'b0, CSR_STATUS, 32'b0, rd, err);
        assert (rd[0] == 1'b0) else report_error("fault still set after remapping");

        // Arrival-order delivery
        sort_copy = 1'b0;
        apb_access(1'b1, CSR_CTRL, 32'h2, rd, err);
        run_traffic(30);

        apb_access(1'b0, CSR_RSP_COUNT, 32'b0, rd, err);
        assert (rd == 32'(accepted))
            else report_error($sformatf("RSP_COUNT reads %0d, expected %0d", rd, accepted));
        $display("TEST OK");
        $finish;
    end

endmodule

// File: sim.f
common/mem_shim_pkg.sv
source/shim_fifo.sv
source/shim_csr.sv
vtp/shim_vtp.sv
rsp_order/shim_rsp_order.sv
source/mem_shim_top.sv
testbench/tb_mem_shim.sv

// File: run.sh
#!/bin/sh
# Build and run the memory shim testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_mem_shim -f sim.f

out=$(./obj_dir/Vtb_mem_shim 2>&1) || true
echo "$out"
echo "$out" | grep -qx "TEST OK"
